/* flist.f */
logic/cache_geom_pkg.sv
logic/cache_msg_pkg.sv
logic/fifo.sv
logic/pipe_valid_stall.sv
logic/cache_storage.sv
logic/miss_control.sv
logic/cache.sv
verification/clock_gen.sv
verification/mem_responder.sv
verification/tb_cache.sv

/* logic/cache.sv */
`default_nettype none

module cache #(
	parameter int DEPTH = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic us_valid,
	input  cache_geom_pkg::addr_t us_addr,
	input  cache_geom_pkg::side_t us_side,
	output logic us_stall,
	output logic ds_valid,
	output cache_msg_pkg::hit_rsp_t ds_rsp,
	input  logic ds_stall,
	output logic mh_req_valid,
	output cache_geom_pkg::addr_t mh_req_addr,
	input  logic mh_req_stall,
	input  logic mh_fill_valid,
	input  cache_geom_pkg::data_t mh_fill_data,
	output logic mh_fill_stall
);
	// storage read takes two cycles
	localparam int READ_LAT = 2;
	localparam int HIT_DEPTH = DEPTH + 2;
	localparam int RBUF_DEPTH = DEPTH + 2;
	localparam int RQ_DEPTH = DEPTH + 3;
	// each pending fill has its owner in the replay buffer or queue
	localparam int MISS_DEPTH = RBUF_DEPTH + RQ_DEPTH;
	localparam int HIT_CNT_W = $clog2(HIT_DEPTH + 1);

	cache_msg_pkg::pipe_req_t pipe_in, pipe_out;
	logic pipe_in_valid, pipe_out_valid, pipe_stall;
	cache_geom_pkg::addr_t rd_addr;
	cache_geom_pkg::data_t rd_data;
	logic hit, fill_we;
	logic miss_we, miss_match, miss_empty;
	logic hit_we, hit_empty;
	logic [HIT_CNT_W-1:0] hit_free;
	cache_msg_pkg::hit_rsp_t hit_din;
	logic rbuf_we, rbuf_re, rbuf_empty;
	cache_msg_pkg::replay_t rbuf_in, rbuf_out, rq_head;
	logic rq_full, rq_empty, rq_re;

	assign ds_valid = !hit_empty;
	assign mh_req_valid = !miss_empty;
	assign hit_din = '{data: rd_data, side: pipe_out.side};

	miss_control u_ctrl (.*);

	cache_storage u_storage (
		.clk, .rst, .rd_addr,
		.pipe_tag(cache_geom_pkg::addr_tag(pipe_out.addr)),
		.fill_we, .fill_addr(rq_head.addr), .fill_data(mh_fill_data),
		.hit, .rd_data
	);

	pipe_valid_stall #(.DEPTH(READ_LAT), .CNT_W(HIT_CNT_W)) u_pipe (
		.clk, .rst,
		.in_valid(pipe_in_valid), .in_data(pipe_in), .in_stall(pipe_stall),
		.out_valid(pipe_out_valid), .out_data(pipe_out),
		.free_slots(hit_free)
	);

	fifo #(.WIDTH(cache_geom_pkg::ADDR_W), .DEPTH(MISS_DEPTH)) u_miss_fifo (
		.clk, .rst, .we(miss_we), .re(mh_req_valid && !mh_req_stall),
		.din(pipe_out.addr), .dout(mh_req_addr), .full(), .empty(miss_empty),
		.free_slots(), .match_addr(pipe_out.addr), .match(miss_match)
	);

	fifo #(.WIDTH($bits(cache_msg_pkg::hit_rsp_t)), .DEPTH(HIT_DEPTH)) u_hit_fifo (
		.clk, .rst, .we(hit_we), .re(ds_valid && !ds_stall),
		.din(hit_din), .dout(ds_rsp), .full(), .empty(hit_empty),
		.free_slots(hit_free), .match_addr('0), .match()
	);

	fifo #(.WIDTH($bits(cache_msg_pkg::replay_t)), .DEPTH(RBUF_DEPTH)) u_rbuf (
		.clk, .rst, .we(rbuf_we), .re(rbuf_re),
		.din(rbuf_in), .dout(rbuf_out), .full(), .empty(rbuf_empty),
		.free_slots(), .match_addr('0), .match()
	);

	fifo #(.WIDTH($bits(cache_msg_pkg::replay_t)), .DEPTH(RQ_DEPTH)) u_rq (
		.clk, .rst, .we(rbuf_re), .re(rq_re),
		.din(rbuf_out), .dout(rq_head), .full(rq_full), .empty(rq_empty),
		.free_slots(), .match_addr('0), .match()
	);

endmodule

`default_nettype wire

/* logic/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

	localparam int ADDR_W = 8;
	// tag, index and block offset add up to ADDR_W
	localparam int TAG_W = 3;
	localparam int INDEX_W = 4;
	localparam int BLK_W = 1;
	localparam int SIDE_W = 4;
	localparam int DATA_W = 16;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [SIDE_W-1:0] side_t;
	typedef logic [DATA_W-1:0] data_t;

	// tag sits at the top of the address
	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[BLK_W +: INDEX_W];
	endfunction

endpackage

`default_nettype wire

/* logic/cache_msg_pkg.sv */
`default_nettype none

package cache_msg_pkg;

	// request as it moves through the read pipeline
	typedef struct packed {
		cache_geom_pkg::side_t side;
		cache_geom_pkg::addr_t addr;
	} pipe_req_t;

	// downstream response
	typedef struct packed {
		cache_geom_pkg::data_t data;
		cache_geom_pkg::side_t side;
	} hit_rsp_t;

	// parked miss
	// wait_flag set when this entry owns the outstanding fill
	typedef struct packed {
		cache_geom_pkg::addr_t addr;
		cache_geom_pkg::side_t side;
		logic wait_flag;
	} replay_t;

	typedef enum logic [1:0] {
		IDLE,
		REPLAY,
		STALL
	} ctrl_state_e;

endpackage

`default_nettype wire

/* logic/cache_storage.sv */
`default_nettype none

module cache_storage (
	input  logic clk,
	input  logic rst,
	input  cache_geom_pkg::addr_t rd_addr,
	input  cache_geom_pkg::tag_t pipe_tag,
	input  logic fill_we,
	input  cache_geom_pkg::addr_t fill_addr,
	input  cache_geom_pkg::data_t fill_data,
	output logic hit,
	output cache_geom_pkg::data_t rd_data
);
	localparam int SETS = 1 << cache_geom_pkg::INDEX_W;

	cache_geom_pkg::data_t data0 [SETS];
	cache_geom_pkg::data_t data1 [SETS];
	cache_geom_pkg::tag_t tag0 [SETS];
	cache_geom_pkg::tag_t tag1 [SETS];
	logic [SETS-1:0] val0, val1;
	// way to replace next, per set
	logic [SETS-1:0] repl;

	cache_geom_pkg::index_t rd_idx, wr_idx;
	cache_geom_pkg::tag_t wr_tag;
	logic present0, present1, wr_way, fwd0, fwd1;

	// read stage a and b
	logic v0a, v1a, v0b, v1b;
	cache_geom_pkg::tag_t t0a, t1a, t0b, t1b;
	cache_geom_pkg::data_t d0a, d1a, d0b, d1b;
	logic hit0, hit1;

	assign rd_idx = cache_geom_pkg::addr_index(rd_addr);
	assign wr_idx = cache_geom_pkg::addr_index(fill_addr);
	assign wr_tag = cache_geom_pkg::addr_tag(fill_addr);

	// a repeated fill refreshes its own way, so a tag never sits in both
	assign present0 = val0[wr_idx] && (tag0[wr_idx] == wr_tag);
	assign present1 = val1[wr_idx] && (tag1[wr_idx] == wr_tag);
	assign wr_way = present0 ? 1'b0 : (present1 ? 1'b1 : repl[wr_idx]);

	assign fwd0 = fill_we && !wr_way && (wr_idx == rd_idx);
	assign fwd1 = fill_we && wr_way && (wr_idx == rd_idx);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			val0 <= '0;
			val1 <= '0;
			repl <= '0;
			v0a <= 1'b0;
			v1a <= 1'b0;
			v0b <= 1'b0;
			v1b <= 1'b0;
		end else begin
			if (fill_we) begin
				if (wr_way)
					val1[wr_idx] <= 1'b1;
				else
					val0[wr_idx] <= 1'b1;
				if (!present0 && !present1)
					repl[wr_idx] <= ~repl[wr_idx];
			end
			v0a <= fwd0 | val0[rd_idx];
			v1a <= fwd1 | val1[rd_idx];
			v0b <= v0a;
			v1b <= v1a;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_we && !wr_way) begin
			data0[wr_idx] <= fill_data;
			tag0[wr_idx] <= wr_tag;
		end
		if (fill_we && wr_way) begin
			data1[wr_idx] <= fill_data;
			tag1[wr_idx] <= wr_tag;
		end
		// same-index fill goes straight into stage a
		t0a <= fwd0 ? wr_tag : tag0[rd_idx];
		d0a <= fwd0 ? fill_data : data0[rd_idx];
		t1a <= fwd1 ? wr_tag : tag1[rd_idx];
		d1a <= fwd1 ? fill_data : data1[rd_idx];
		t0b <= t0a;
		d0b <= d0a;
		t1b <= t1a;
		d1b <= d1a;
	end

	assign hit0 = v0b && (t0b == pipe_tag);
	assign hit1 = v1b && (t1b == pipe_tag);
	assign hit = hit0 | hit1;
	assign rd_data = hit0 ? d0b : d1b;

	a_one_way: assert property (@(posedge clk) disable iff (rst) !(hit0 && hit1))
		else $error("both ways hit on one lookup");

endmodule

`default_nettype wire

/* logic/fifo.sv */
`default_nettype none

module fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic we,
	input  logic re,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout,
	output logic full,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] free_slots,
	input  cache_geom_pkg::addr_t match_addr,
	output logic match
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH+1);

	logic [WIDTH-1:0] mem [DEPTH];
	// occupancy per slot, used by the address search
	logic [DEPTH-1:0] occ;
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			occ <= '0;
		end else begin
			if (we) begin
				occ[wr_ptr] <= 1'b1;
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (re) begin
				occ[rd_ptr] <= 1'b0;
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			if (we && !re)
				count <= count + 1'b1;
			else if (re && !we)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_ptr] <= din;
	end

	assign dout = mem[rd_ptr];
	assign full = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign free_slots = CW'(DEPTH) - count;

	// compare low address bits of every held entry
	always_comb begin
		match = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (occ[i] && mem[i][cache_geom_pkg::ADDR_W-1:0] == match_addr)
				match = 1'b1;
		end
	end

	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		!(we && full) && !(re && empty))
		else $error("fifo written when full or read when empty");

endmodule

`default_nettype wire

/* logic/miss_control.sv */
`default_nettype none

module miss_control (
	input  logic clk,
	input  logic rst,
	input  logic us_valid,
	input  cache_geom_pkg::addr_t us_addr,
	input  cache_geom_pkg::side_t us_side,
	output logic us_stall,
	output cache_msg_pkg::pipe_req_t pipe_in,
	output logic pipe_in_valid,
	input  logic pipe_stall,
	input  cache_msg_pkg::pipe_req_t pipe_out,
	input  logic pipe_out_valid,
	input  logic hit,
	input  logic miss_match,
	output logic miss_we,
	output logic hit_we,
	output logic rbuf_we,
	output logic rbuf_re,
	output cache_msg_pkg::replay_t rbuf_in,
	input  logic rbuf_empty,
	input  logic rq_full,
	input  logic rq_empty,
	input  cache_msg_pkg::replay_t rq_head,
	output logic rq_re,
	input  logic mh_fill_valid,
	output logic mh_fill_stall,
	output logic fill_we,
	output cache_geom_pkg::addr_t rd_addr
);
	cache_msg_pkg::ctrl_state_e state, state_next;
	logic replay_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= cache_msg_pkg::IDLE;
		else
			state <= state_next;
	end

	// STALL holds upstream until the queue has room and the buffer drained
	always_comb begin
		state_next = state;
		case (state)
			cache_msg_pkg::IDLE: begin
				if (rq_full)
					state_next = cache_msg_pkg::STALL;
				else if (!rq_empty)
					state_next = cache_msg_pkg::REPLAY;
			end
			cache_msg_pkg::REPLAY: begin
				if (rq_full)
					state_next = cache_msg_pkg::STALL;
				else if (rq_empty)
					state_next = cache_msg_pkg::IDLE;
			end
			cache_msg_pkg::STALL: begin
				if (!rq_full && rbuf_empty)
					state_next = rq_empty ? cache_msg_pkg::IDLE : cache_msg_pkg::REPLAY;
			end
			default: state_next = cache_msg_pkg::IDLE;
		endcase
	end

	// waiting head only leaves together with its fill beat
	assign replay_ready = (state != cache_msg_pkg::IDLE) && !rq_empty &&
		(!rq_head.wait_flag || mh_fill_valid);
	assign rq_re = replay_ready && !pipe_stall;
	assign fill_we = rq_re && rq_head.wait_flag;
	assign mh_fill_stall = mh_fill_valid && !fill_we;

	// replays win over new requests
	assign us_stall = pipe_stall || rq_full || replay_ready || (state == cache_msg_pkg::STALL);
	assign pipe_in_valid = rq_re || (us_valid && !us_stall);

	always_comb begin
		if (rq_re) begin
			pipe_in.side = rq_head.side;
			pipe_in.addr = rq_head.addr;
		end else begin
			pipe_in.side = us_side;
			pipe_in.addr = us_addr;
		end
	end
	assign rd_addr = pipe_in.addr;

	// pipeline output sorting
	assign hit_we = pipe_out_valid && hit;
	assign rbuf_we = pipe_out_valid && !hit;
	assign miss_we = pipe_out_valid && !hit && !miss_match;
	assign rbuf_in = '{addr: pipe_out.addr, side: pipe_out.side, wait_flag: !miss_match};
	assign rbuf_re = !rbuf_empty && !rq_full;

	// a waiting replay travels with its fill beat and so comes back out as a hit
	a_fill_with_wait: assert property (@(posedge clk) disable iff (rst)
		$past(rq_re && rq_head.wait_flag, 2) |-> pipe_out_valid && hit)
		else $error("waiting replay did not come back as a hit with its fill");

endmodule

`default_nettype wire

/* logic/pipe_valid_stall.sv */
`default_nettype none

module pipe_valid_stall #(
	parameter int WIDTH = $bits(cache_msg_pkg::pipe_req_t),
	parameter int DEPTH = 2,
	parameter int CNT_W = 3
) (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  cache_msg_pkg::pipe_req_t in_data,
	output logic in_stall,
	output logic out_valid,
	output cache_msg_pkg::pipe_req_t out_data,
	input  logic [CNT_W-1:0] free_slots
);
	logic [DEPTH-1:0] vld;
	logic [WIDTH-1:0] payload [DEPTH];
	logic [CNT_W-1:0] in_flight;

	// items already committed to the downstream FIFO
	always_comb begin
		in_flight = '0;
		for (int i = 0; i < DEPTH; i++) begin
			in_flight = in_flight + CNT_W'(vld[i]);
		end
	end

	// need at least one free slot beyond what is in flight
	assign in_stall = (free_slots <= in_flight);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld <= '0;
		end else begin
			vld[0] <= in_valid & ~in_stall;
			for (int i = 1; i < DEPTH; i++) begin
				vld[i] <= vld[i-1];
			end
		end
	end

	// payload shifts every cycle, validity tells what is real
	always_ff @(posedge clk) begin
		payload[0] <= in_data;
		for (int i = 1; i < DEPTH; i++) begin
			payload[i] <= payload[i-1];
		end
	end

	assign out_valid = vld[DEPTH-1];
	assign out_data = payload[DEPTH-1];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cache -f flist.f -o sim_cache &&
	./obj_dir/sim_cache | tee /dev/stderr | grep -q "Result: PASSED" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

/* verification/clock_gen.sv */
`default_nettype none

module clock_gen #(
	parameter int HALF = 10,
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	// release lands just after an edge, like the other inputs
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* verification/mem_responder.sv */
`default_nettype none

module mem_responder #(
	parameter int DELAY = 6
) (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  cache_geom_pkg::addr_t req_addr,
	output logic req_stall,
	input  logic hold,
	output logic fill_valid,
	output cache_geom_pkg::data_t fill_data,
	input  logic fill_stall
);
	logic busy = 1'b0;
	logic fv = 1'b0;
	cache_geom_pkg::data_t fd = '0;
	cache_geom_pkg::addr_t addr_q = '0;
	cache_geom_pkg::addr_t take_addr = '0;
	logic take = 1'b0;
	logic done = 1'b0;
	int cnt = 0;

	// line contents depend on tag and index only
	function automatic cache_geom_pkg::data_t line_data(cache_geom_pkg::addr_t a);
		return {2'b10, a[7:1], a[7:1] ^ 7'h55};
	endfunction

	// one fill in flight at a time
	assign req_stall = busy || hold;
	assign fill_valid = fv;
	assign fill_data = fd;

	// sample handshakes where the DUT outputs are settled
	always @(negedge clk) begin
		take = req_valid && !req_stall;
		take_addr = req_addr;
		done = fv && !fill_stall;
	end

	always @(posedge clk) begin
		#2;
		if (rst) begin
			busy = 1'b0;
			fv = 1'b0;
			cnt = 0;
		end else begin
			if (done) begin
				fv = 1'b0;
				busy = 1'b0;
			end else if (busy && !fv) begin
				cnt = cnt - 1;
				if (cnt == 0) begin
					fv = 1'b1;
					fd = line_data(addr_q);
				end
			end
			if (take) begin
				busy = 1'b1;
				addr_q = take_addr;
				cnt = DELAY;
			end
		end
	end

endmodule

`default_nettype wire

/* verification/tb_cache.sv */
`default_nettype none

module tb_cache;
	logic clk, rst;
	logic us_valid = 1'b0;
	cache_geom_pkg::addr_t us_addr = '0;
	cache_geom_pkg::side_t us_side = '0;
	logic us_stall, ds_valid;
	logic ds_stall = 1'b0;
	cache_msg_pkg::hit_rsp_t ds_rsp;
	logic mh_req_valid, mh_req_stall, mh_fill_valid, mh_fill_stall;
	cache_geom_pkg::addr_t mh_req_addr;
	cache_geom_pkg::data_t mh_fill_data;
	logic req_hold = 1'b0;
	logic rand_hold = 1'b0;
	logic rand_stall = 1'b0;
	logic timed_out = 1'b0;
	integer seed = 32'h7270bbe7;
	int cycle = 0;
	int errors = 0;
	int mon_errors = 0;
	int fills = 0;
	int last_latency = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	// scoreboard keyed by side
	int issued [16];
	int done [16];
	cache_geom_pkg::addr_t pend_addr [16];
	int accept_cyc [16];

	clock_gen u_clk (.clk, .rst);

	mem_responder u_mem (
		.clk, .rst, .req_valid(mh_req_valid), .req_addr(mh_req_addr),
		.req_stall(mh_req_stall), .hold(req_hold | rand_hold),
		.fill_valid(mh_fill_valid), .fill_data(mh_fill_data), .fill_stall(mh_fill_stall)
	);

	cache #(.DEPTH(2)) DUT (.*);

	// expected line data from the address rule of the miss handler
	function automatic cache_geom_pkg::data_t expect_data(cache_geom_pkg::addr_t a);
		return {2'b10, a[7:1], a[7:1] ^ 7'h55};
	endfunction

	function automatic int busy_sides();
		int n;
		n = 0;
		for (int i = 0; i < 16; i++) begin
			if (issued[i] != done[i])
				n++;
		end
		return n;
	endfunction

	always @(posedge clk) cycle <= cycle + 1;

	// compare every downstream transfer and count fill requests
	always @(negedge clk) begin
		if (!rst) begin
			if (mh_req_valid && !mh_req_stall)
				fills++;
			if (ds_valid && !ds_stall) begin
				if (issued[ds_rsp.side] == done[ds_rsp.side]) begin
					mon_errors++;
					$display("response at %0t for side %0d, which has no request outstanding",
						$time, ds_rsp.side);
				end else begin
					if (ds_rsp.data !== expect_data(pend_addr[ds_rsp.side])) begin
						mon_errors++;
						$display("[FAIL] %0t ds_rsp.data expected %h got %h", $time,
							expect_data(pend_addr[ds_rsp.side]), ds_rsp.data);
					end
					done[ds_rsp.side]++;
					last_latency = cycle - accept_cyc[ds_rsp.side];
				end
			end
		end
	end

	task automatic tick();
		@(posedge clk);
		#2;
		if (rand_stall) begin
			ds_stall = ($random(seed) % 3) == 0;
			rand_hold = ($random(seed) % 2) == 0;
		end
	endtask

	task automatic issue(input cache_geom_pkg::addr_t a, input cache_geom_pkg::side_t s);
		int n;
		n = 0;
		us_valid = 1'b1;
		us_addr = a;
		us_side = s;
		while (n < 200 && !timed_out) begin
			@(negedge clk);
			if (!us_stall) begin
				pend_addr[s] = a;
				accept_cyc[s] = cycle;
				issued[s]++;
				tick();
				us_valid = 1'b0;
				return;
			end
			tick();
			n++;
		end
		us_valid = 1'b0;
		timed_out = 1'b1;
		$display("timeout: request for side %0d was never accepted", s);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (busy_sides() != 0 && n < 3000 && !timed_out) begin
			tick();
			n++;
		end
		if (busy_sides() != 0) begin
			timed_out = 1'b1;
			$display("timeout: %0d sides still wait for a response", busy_sides());
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		if (errors + mon_errors == err_before && !timed_out) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: failed", name);
		end
	endtask

	initial begin
		int e0;
		int f0;
		int n;
		int r0;
		cache_geom_pkg::side_t s;
		for (int i = 0; i < 16; i++) begin
			issued[i] = 0;
			done[i] = 0;
		end
		tick();
		n = 0;
		while (rst && n < 50) begin
			tick();
			n++;
		end

		// test 1 covers reset state and the first miss
		e0 = errors + mon_errors;
		if (ds_valid !== 1'b0 || mh_req_valid !== 1'b0 || mh_fill_stall !== 1'b0) begin
			errors++;
			$display("[FAIL] %0t ds_valid/mh_req_valid/mh_fill_stall expected 000 got %b%b%b",
				$time, ds_valid, mh_req_valid, mh_fill_stall);
		end
		issue(8'h34, 4'd1);
		drain();
		if (fills != 1) begin
			errors++;
			$display("[FAIL] %0t fill requests expected 1 got %0d", $time, fills);
		end
		end_test("reset_and_first_miss", e0);

		// test 2 hits the filled line through its other block offset
		e0 = errors + mon_errors;
		f0 = fills;
		issue(8'h35, 4'd2);
		drain();
		if (last_latency != 3) begin
			errors++;
			$display("[FAIL] %0t hit latency expected 3 got %0d", $time, last_latency);
		end
		if (fills != f0) begin
			errors++;
			$display("[FAIL] %0t fill requests expected %0d got %0d", $time, f0, fills);
		end
		end_test("hit_latency", e0);

		// test 3 holds the miss handler so all three misses meet the queued request
		e0 = errors + mon_errors;
		f0 = fills;
		req_hold = 1'b1;
		issue(8'h7c, 4'd3);
		issue(8'h7c, 4'd4);
		issue(8'h7c, 4'd5);
		repeat (4) tick();
		req_hold = 1'b0;
		drain();
		if (fills - f0 != 1) begin
			errors++;
			$display("[FAIL] %0t fill requests expected 1 got %0d", $time, fills - f0);
		end
		end_test("merged_misses", e0);

		// test 4 fills three tags into set 5 and the third evicts the first
		e0 = errors + mon_errors;
		issue(8'h0a, 4'd6);
		drain();
		issue(8'h2a, 4'd7);
		drain();
		issue(8'h4a, 4'd8);
		drain();
		f0 = fills;
		issue(8'h4a, 4'd9);
		drain();
		// second tag stays in the other way
		issue(8'h2a, 4'd11);
		drain();
		if (fills != f0) begin
			errors++;
			$display("[FAIL] %0t fill requests expected %0d got %0d", $time, f0, fills);
		end
		issue(8'h0a, 4'd10);
		drain();
		if (fills != f0 + 1) begin
			errors++;
			$display("[FAIL] %0t fill requests expected %0d got %0d", $time, f0 + 1, fills);
		end
		end_test("set_eviction", e0);

		// test 5 sends a random stream under random back-pressure
		e0 = errors + mon_errors;
		r0 = 0;
		for (int i = 0; i < 16; i++)
			r0 = r0 + done[i];
		rand_stall = 1'b1;
		for (int k = 0; k < 60 && !timed_out; k++) begin
			n = 0;
			while (busy_sides() == 16 && n < 3000) begin
				tick();
				n++;
			end
			if (busy_sides() == 16) begin
				timed_out = 1'b1;
				$display("timeout: every side still waits for a response");
			end else begin
				s = cache_geom_pkg::side_t'($random(seed));
				while (issued[s] != done[s])
					s = s + 1'b1;
				issue(cache_geom_pkg::addr_t'($random(seed)), s);
			end
		end
		rand_stall = 1'b0;
		ds_stall = 1'b0;
		rand_hold = 1'b0;
		drain();
		n = 0;
		for (int i = 0; i < 16; i++)
			n = n + done[i];
		if (n - r0 != 60) begin
			errors++;
			$display("[FAIL] %0t responses expected 60 got %0d", $time, n - r0);
		end
		end_test("random_stream", e0);

		$display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt,
			errors + mon_errors);
		if (errors + mon_errors == 0 && fail_cnt == 0 && !timed_out)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
